// File: branchPredictor.f
verilog/BranchPkg.sv
verilog/BranchTargetBuffer.sv
verilog/BranchPredictionTable.sv
verilog/BranchPredictor.sv
bench/BranchPredictorTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := BranchPredictorTb
FILELIST  := branchPredictor.f
OBJDIR    := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/BranchPredictorTb.sv
`timescale 1ns/100ps

module BranchPredictorTb import BranchPkg::*; ();

    localparam int OP_LOOK = 0;
    localparam int OP_UPD = 1;
    localparam int OP_COM = 2;
    localparam int OP_FLUSH = 3;
    localparam int OP_MISS = 4;
    localparam int ENTRIES = 8;

    typedef struct {
        int op;
        logic [31:0] a;      // pc, src or commit ID
        logic [31:0] b;      // Update target
        logic j;             // isJump or commit outcome
        logic c;
        logic both;          // Port 0 also carries a losing update
        logic eFound;
        logic [31:0] eSrc;
        logic [31:0] eDst;
        logic eJ;
        logic eC;
        logic eM;
    } Row;

    logic clk;
    logic rst;
    logic mispredFlush;
    logic pcValid;
    logic [ADDR_BITS-1:0] pc;
    logic branchTaken;
    logic isJump;
    logic multipleBranches;
    logic branchFound;
    logic branchCompr;
    logic [ADDR_BITS-1:0] branchSrc;
    logic [ADDR_BITS-1:0] branchDst;
    logic [7:0] branchID;
    BTUpdate btUpdates [2];
    CommitUOp comUOp;

    Row rows[$];
    logic [15:0] lfsr = 16'd13365;
    logic [1:0] mCnt [256];   // Reference model state
    logic [7:0] mSpec;
    logic [7:0] mCom;
    logic [ENTRIES-1:0] mValid;
    logic [ENTRIES-1:0] mUsed;
    logic [31:0] mSrc [ENTRIES];
    logic mJump [ENTRIES];

    BranchPredictor #(.NUM_IN(2), .NUM_ENTRIES(ENTRIES), .ID_BITS(8)) UUT (
        .clk(clk), .rst(rst), .mispredFlush(mispredFlush),
        .pcValid(pcValid), .pc(pc), .branchTaken(branchTaken), .isJump(isJump),
        .branchSrc(branchSrc), .branchDst(branchDst), .branchID(branchID),
        .multipleBranches(multipleBranches), .branchFound(branchFound),
        .branchCompr(branchCompr), .btUpdates(btUpdates), .comUOp(comUOp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    function automatic Row mkRow(input int op, input logic [31:0] a, input logic [31:0] b);
        Row r;
        r = '{op: op, a: a, b: b, default: '0};
        return r;
    endfunction

    task automatic addLookup(input logic [31:0] p, input logic f, input logic [31:0] s,
                             input logic [31:0] d, input logic j, input logic c,
                             input logic m);
        Row r;
        r = mkRow(OP_LOOK, p, 0);
        r.eFound = f;
        r.eSrc = s;
        r.eDst = d;
        r.eJ = j;
        r.eC = c;
        r.eM = m;
        rows.push_back(r);
    endtask

    task automatic addUpdate(input logic [31:0] s, input logic [31:0] d, input logic j,
                             input logic c, input logic both);
        Row r;
        r = mkRow(OP_UPD, s, d);
        r.j = j;
        r.c = c;
        r.both = both;
        rows.push_back(r);
    endtask

    task automatic addCommit(input logic [7:0] id, input logic t);
        Row r;
        r = mkRow(OP_COM, 32'(id), 0);
        r.j = t;
        rows.push_back(r);
    endtask

    // Index of the lowest src at or above p in the same block or -1
    function automatic int modelFind(input logic [31:0] p);
        int best;
        best = -1;
        for (int i = 0; i < ENTRIES; i++)
            if (mValid[i] && mSrc[i][31:3] == p[31:3] && mSrc[i][2:0] >= p[2:0])
                if (best < 0 || mSrc[i] < mSrc[best])
                    best = i;
        return best;
    endfunction

    function automatic void modelMark(input int idx);
        mUsed[idx] = 1'b1;
        if (&mUsed) begin
            mUsed = '0;
            mUsed[idx] = 1'b1;
        end
    endfunction

    function automatic void modelInsert(input logic [31:0] s, input logic j);
        int idx;
        idx = -1;
        for (int i = 0; i < ENTRIES; i++)
            if (mValid[i] && mSrc[i] == s)
                idx = i;
        if (idx < 0) begin
            for (int i = ENTRIES - 1; i >= 0; i--)
                if (!mUsed[i])
                    idx = i;
            modelMark(idx);
        end
        mValid[idx] = 1'b1;
        mSrc[idx] = s;
        mJump[idx] = j;
    endfunction

    task automatic applyRow(input Row r);
        logic [7:0] expId;
        logic expTaken;
        int hit;
        logic [31:0] rnd;
        pcValid = 1'b0;
        mispredFlush = 1'b0;
        btUpdates[0] = '0;
        btUpdates[1] = '0;
        comUOp = '0;
        if (r.op == OP_MISS) begin
            rnd = randomBits(27);
            r.a = {4'hF, rnd[26:0], 1'b0};  // No entry lives above 0xF0000000
        end
        case (r.op)
            OP_LOOK, OP_MISS: begin
                pcValid = 1'b1;
                pc = r.a;
            end
            OP_UPD: begin
                btUpdates[1] = '{1'b1, r.a, r.b, r.j, r.c};
                if (r.both)
                    btUpdates[0] = '{1'b1, 32'h1800, 32'h0, 1'b0, 1'b0};
            end
            OP_COM: comUOp = '{1'b1, 1'b1, r.j, r.a[7:0]};
            default: mispredFlush = 1'b1;
        endcase
        #18;
        if (r.op == OP_LOOK || r.op == OP_MISS) begin
            expId = r.a[8:1] ^ mSpec;
            expTaken = mCnt[expId][1];
            hit = modelFind(r.a);
            assert ((hit >= 0) == r.eFound) else begin
                $display("Reference model and stimulus table disagree on a hit at pc %h", r.a);
                $display("Checks failed");
                $fatal(1);
            end
            checkVal("branchID", 32'(branchID), 32'(expId));
            checkVal("branchTaken", 32'(branchTaken), 32'(expTaken));
            checkVal("branchFound", 32'(branchFound), 32'(r.eFound));
            checkVal("multipleBranches", 32'(multipleBranches), 32'(r.eM));
            if (r.eFound) begin
                checkVal("branchSrc", branchSrc, r.eSrc);
                checkVal("branchDst", branchDst, r.eDst);
                checkVal("isJump", 32'(isJump), 32'(r.eJ));
                checkVal("branchCompr", 32'(branchCompr), 32'(r.eC));
                modelMark(hit);
                if (!mJump[hit])
                    mSpec = {mSpec[6:0], expTaken};
            end
        end else if (r.op == OP_UPD) begin
            modelInsert(r.a, r.j);
        end else if (r.op == OP_COM) begin
            if (r.j && mCnt[r.a[7:0]] != 2'd3)
                mCnt[r.a[7:0]] = mCnt[r.a[7:0]] + 2'd1;
            else if (!r.j && mCnt[r.a[7:0]] != 2'd0)
                mCnt[r.a[7:0]] = mCnt[r.a[7:0]] - 2'd1;
            mCom = {mCom[6:0], r.j};
        end else begin
            mSpec = mCom;
        end
    endtask

    initial begin
        int waited;
        rst = 1'b1;
        pcValid = 1'b0;
        pc = '0;
        mispredFlush = 1'b0;
        btUpdates[0] = '0;
        btUpdates[1] = '0;
        comUOp = '0;
        mSpec = '0;
        mCom = '0;
        mValid = '0;
        mUsed = '0;
        for (int i = 0; i < 256; i++)
            mCnt[i] = 2'd1;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        waited = 0;
        while (branchFound !== 1'b0 || multipleBranches !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > 10) begin
                $display("BTB outputs did not settle low after reset");
                $display("Checks failed");
                $fatal(1);
            end
        end

        repeat (3) rows.push_back(mkRow(OP_MISS, 0, 0));
        addUpdate(32'h1000, 32'h2000, 0, 0, 1);     // Port 1 must win
        addLookup(32'h1000, 1, 32'h1000, 32'h2000, 0, 0, 0);
        addLookup(32'h1800, 0, 0, 0, 0, 0, 0);
        addUpdate(32'h1000, 32'h3000, 0, 0, 0);     // Rewrite in place
        addLookup(32'h1000, 1, 32'h1000, 32'h3000, 0, 0, 0);
        addUpdate(32'h1006, 32'h4000, 0, 1, 0);
        addLookup(32'h1000, 1, 32'h1000, 32'h3000, 0, 0, 1);
        addLookup(32'h1002, 1, 32'h1006, 32'h4000, 0, 1, 0);
        repeat (3) addCommit(8'h00, 1);              // Third one saturates
        addLookup(32'h1000, 1, 32'h1000, 32'h3000, 0, 0, 1);
        addCommit(8'h00, 0);
        addLookup(32'h1000, 1, 32'h1000, 32'h3000, 0, 0, 1);
        addUpdate(32'h1100, 32'h5000, 1, 0, 0);
        addLookup(32'h1100, 1, 32'h1100, 32'h5000, 1, 0, 0);
        addLookup(32'h1100, 1, 32'h1100, 32'h5000, 1, 0, 0);
        rows.push_back(mkRow(OP_FLUSH, 0, 0));
        addLookup(32'h1000, 1, 32'h1000, 32'h3000, 0, 0, 1);
        for (int i = 0; i < 6; i++)                  // Fills slots 3..7 then evicts slot 0
            addUpdate(32'h1200 + 32'(i * 8), 32'h6000 + 32'(i), 0, 0, 0);
        addLookup(32'h1000, 1, 32'h1006, 32'h4000, 0, 1, 0);
        addLookup(32'h1100, 1, 32'h1100, 32'h5000, 1, 0, 0);
        for (int i = 0; i < 6; i++)
            addLookup(32'h1200 + 32'(i * 8), 1, 32'h1200 + 32'(i * 8),
                      32'h6000 + 32'(i), 0, 0, 0);
        rows.push_back(mkRow(OP_MISS, 0, 0));

        foreach (rows[i]) begin
            @(posedge clk);
            #2;
            applyRow(rows[i]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog/BranchPredictor.sv
`timescale 1ns/100ps

module BranchPredictor import BranchPkg::*; #(
    parameter int NUM_IN = 2,
    parameter int NUM_ENTRIES = 32,
    parameter int ID_BITS = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic mispredFlush,

    // Fetch side
    input  logic pcValid,
    input  logic [ADDR_BITS-1:0] pc,
    output logic branchTaken,
    output logic isJump,
    output logic [ADDR_BITS-1:0] branchSrc,
    output logic [ADDR_BITS-1:0] branchDst,
    output logic [ID_BITS-1:0] branchID,
    output logic multipleBranches,
    output logic branchFound,
    output logic branchCompr,

    // Execution units
    input  BTUpdate btUpdates [NUM_IN],

    // Commit stream
    input  CommitUOp comUOp
);

    // History width is bounded by the ID field of the commit record
    if (ID_BITS < 1 || ID_BITS > COMMIT_ID_BITS) begin : gIdBitsCheck
        $error("ID_BITS must lie between 1 and %0d", COMMIT_ID_BITS);
    end

    logic [ID_BITS-1:0] specHistory;   // Advanced at fetch
    logic [ID_BITS-1:0] comHistory;    // Advanced at commit
    BTUpdate btUpdate;
    logic comBranch;

    // Highest valid index wins
    always_comb begin
        btUpdate = '0;
        for (int i = 0; i < NUM_IN; i++) begin
            if (btUpdates[i].valid)
                btUpdate = btUpdates[i];
        end
    end

    assign branchID = pc[ID_BITS:1] ^ specHistory;  // gshare hash
    assign comBranch = comUOp.valid && comUOp.isBranch;

    BranchTargetBuffer #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) btb (
        .clk(clk),
        .rst(rst),
        .pcValid(pcValid),
        .pc(pc),
        .btUpdate(btUpdate),
        .branchFound(branchFound),
        .branchSrc(branchSrc),
        .branchDst(branchDst),
        .branchIsJump(isJump),
        .branchCompr(branchCompr),
        .multipleBranches(multipleBranches)
    );

    BranchPredictionTable #(
        .ID_BITS(ID_BITS)
    ) bpt (
        .clk(clk),
        .rst(rst),
        .readAddr(branchID),
        .writeEn(comBranch),
        .writeAddr(comUOp.branchID[ID_BITS-1:0]),
        .writeTaken(comUOp.branchTaken),
        .taken(branchTaken)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            specHistory <= '0;
            comHistory <= '0;
        end else begin
            if (mispredFlush)
                specHistory <= comHistory;  // Restore wins over fetch shift
            else if (pcValid && branchFound && !isJump)
                specHistory <= ID_BITS'({specHistory, branchTaken});

            if (comBranch)
                comHistory <= ID_BITS'({comHistory, comUOp.branchTaken});
        end
    end

endmodule

// File: verilog/BranchPredictionTable.sv
`timescale 1ns/100ps

module BranchPredictionTable #(
    parameter int ID_BITS = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic [ID_BITS-1:0] readAddr,
    input  logic writeEn,
    input  logic [ID_BITS-1:0] writeAddr,
    input  logic writeTaken,
    output logic taken
);

    localparam int NUM_COUNTERS = 2 ** ID_BITS;

    // 2-bit saturating counters, 0..1 not taken, 2..3 taken
    logic [1:0] counters [NUM_COUNTERS];

    // Read sees the value before any same-cycle write
    assign taken = counters[readAddr][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_COUNTERS; i++)
                counters[i] <= 2'd1;  // Weakly not taken
        end else if (writeEn) begin
            if (writeTaken) begin
                if (counters[writeAddr] != 2'd3)
                    counters[writeAddr] <= counters[writeAddr] + 2'd1;
            end else begin
                if (counters[writeAddr] != 2'd0)
                    counters[writeAddr] <= counters[writeAddr] - 2'd1;
            end
        end
    end

    // Commit stream must carry a clean ID with every branch
    assert property (@(posedge clk) disable iff (rst) writeEn |-> !$isunknown(writeAddr))
        else $error("Counter write with unknown address");

endmodule

// File: verilog/BranchTargetBuffer.sv
`timescale 1ns/100ps

module BranchTargetBuffer import BranchPkg::*; #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic pcValid,
    input  logic [ADDR_BITS-1:0] pc,
    input  BTUpdate btUpdate,
    output logic branchFound,
    output logic [ADDR_BITS-1:0] branchSrc,
    output logic [ADDR_BITS-1:0] branchDst,
    output logic branchIsJump,
    output logic branchCompr,
    output logic multipleBranches
);

    localparam int IDX_BITS = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    // Control state
    logic [NUM_ENTRIES-1:0] entryValid;
    logic [NUM_ENTRIES-1:0] entryUsed;  // Pseudo-LRU bits
    // Payload
    logic [ADDR_BITS-1:0] entrySrc [NUM_ENTRIES];
    logic [ADDR_BITS-1:0] entryDst [NUM_ENTRIES];
    logic entryIsJump [NUM_ENTRIES];
    logic entryCompr [NUM_ENTRIES];

    logic [IDX_BITS-1:0] hitIdx;
    logic [IDX_BITS-1:0] matchIdx;
    logic [IDX_BITS-1:0] freeIdx;
    logic matchFound;
    logic [IDX_BITS-1:0] writeIdx;
    logic [NUM_ENTRIES-1:0] usedNext;
    logic dupSrc;

    // Set one used bit; if all would end up set, keep only that one
    function automatic logic [NUM_ENTRIES-1:0] markUsed(
        input logic [NUM_ENTRIES-1:0] bits,
        input logic [IDX_BITS-1:0] idx
    );
        logic [NUM_ENTRIES-1:0] result;
        result = bits;
        result[idx] = 1'b1;
        if (&result) begin
            result = '0;
            result[idx] = 1'b1;
        end
        return result;
    endfunction

    // Lookup, first branch at or after pc within its block
    always_comb begin
        logic [BLOCK_BITS-1:0] bestOffs;
        branchFound = 1'b0;
        multipleBranches = 1'b0;
        hitIdx = '0;
        bestOffs = '1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entryValid[i] &&
                entrySrc[i][ADDR_BITS-1:BLOCK_BITS] == pc[ADDR_BITS-1:BLOCK_BITS] &&
                entrySrc[i][BLOCK_BITS-1:0] >= pc[BLOCK_BITS-1:0]) begin
                if (branchFound)
                    multipleBranches = 1'b1;
                if (!branchFound || entrySrc[i][BLOCK_BITS-1:0] < bestOffs) begin
                    hitIdx = IDX_BITS'(i);
                    bestOffs = entrySrc[i][BLOCK_BITS-1:0];
                end
                branchFound = 1'b1;
            end
        end
    end

    assign branchSrc = entrySrc[hitIdx];
    assign branchDst = entryDst[hitIdx];
    assign branchIsJump = entryIsJump[hitIdx];
    assign branchCompr = entryCompr[hitIdx];

    // Existing entry for this src, else lowest unused slot
    always_comb begin
        matchFound = 1'b0;
        matchIdx = '0;
        freeIdx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!entryUsed[i])
                freeIdx = IDX_BITS'(i);
            if (entryValid[i] && entrySrc[i] == btUpdate.src) begin
                matchFound = 1'b1;
                matchIdx = IDX_BITS'(i);
            end
        end
    end

    assign writeIdx = matchFound ? matchIdx : freeIdx;

    always_comb begin
        usedNext = entryUsed;
        if (pcValid && branchFound)
            usedNext = markUsed(usedNext, hitIdx);
        if (btUpdate.valid && !matchFound)  // Fresh insertion
            usedNext = markUsed(usedNext, freeIdx);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            entryUsed <= '0;
        end else begin
            entryUsed <= usedNext;
            if (btUpdate.valid)
                entryValid[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btUpdate.valid) begin
            entrySrc[writeIdx] <= btUpdate.src;
            entryDst[writeIdx] <= btUpdate.dst;
            entryIsJump[writeIdx] <= btUpdate.isJump;
            entryCompr[writeIdx] <= btUpdate.compressed;
        end
    end

    // Insert path must never create a second copy of a src
    always_comb begin
        dupSrc = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++)
            for (int j = i + 1; j < NUM_ENTRIES; j++)
                if (entryValid[i] && entryValid[j] && entrySrc[i] == entrySrc[j])
                    dupSrc = 1'b1;
    end

    assert property (@(posedge clk) disable iff (rst) !dupSrc)
        else $error("BTB holds duplicate src entries");

endmodule

// File: verilog/BranchPkg.sv
package BranchPkg;

    // Address width, bit 0 is always zero
    parameter int ADDR_BITS = 32;

    // Fetch block of 8 bytes, four halfword slots
    parameter int BLOCK_BITS = 3;

    // Width of the branch ID carried through the commit stream
    parameter int COMMIT_ID_BITS = 8;

    // BTB write request from a branch execution unit (67 bits)
    typedef struct packed {
        logic valid;
        logic [ADDR_BITS-1:0] src;   // Address of the branch itself
        logic [ADDR_BITS-1:0] dst;   // Target address
        logic isJump;                // Unconditional
        logic compressed;            // 16-bit encoding
    } BTUpdate;

    // One retiring instruction (11 bits)
    typedef struct packed {
        logic valid;
        logic isBranch;
        logic branchTaken;                    // Resolved outcome
        logic [COMMIT_ID_BITS-1:0] branchID;  // Hash given at fetch
    } CommitUOp;

endpackage
